// File: verilog/ao_periph_pkg.sv
// Always-on peripheral block shared types
// OBI and register bus structs, register offsets and the slot address map
package ao_periph_pkg;

  // OBI slave port, request from the master
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // OBI slave port, response to the master
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } obi_resp_t;

  // Internal register bus, single cycle and always ready
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Bridge FSM
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_ACCESS,
    BR_RESP
  } bridge_state_e;

  // Word offsets inside a timer slot
  typedef enum logic [1:0] {
    TIMER_CTRL  = 2'd0,
    TIMER_CMP   = 2'd1,
    TIMER_COUNT = 2'd2
  } timer_reg_e;

  // Word offsets inside the interrupt slot
  typedef enum logic [1:0] {
    INTR_PENDING = 2'd0,
    INTR_MASK    = 2'd1
  } intr_reg_e;

  // Each slot covers 16 bytes
  localparam int SLOT_LSB = 4;
  // Slot index is addr[11:4]
  localparam int SLOT_BITS = 8;
  // Everything from this bit up must be zero
  localparam int MAP_TOP = 12;

endpackage : ao_periph_pkg

// File: verilog/obi_to_reg.sv
// OBI slave to register bus bridge
// One access in flight, fixed three cycles from grant to the next grant
`timescale 1ns/1ps

module obi_to_reg (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  output ao_periph_pkg::reg_req_t  reg_req_o,
  input  ao_periph_pkg::reg_rsp_t  reg_rsp_i
);

  ao_periph_pkg::bridge_state_e state_q;
  ao_periph_pkg::bridge_state_e state_d;

  logic        gnt;
  logic        we_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic        err_q;

  // Only idle accepts a new request
  assign gnt = (state_q == ao_periph_pkg::BR_IDLE) && obi_req_i.req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ao_periph_pkg::BR_IDLE: begin
        if (gnt) begin
          state_d = ao_periph_pkg::BR_ACCESS;
        end
      end
      ao_periph_pkg::BR_ACCESS: state_d = ao_periph_pkg::BR_RESP;
      ao_periph_pkg::BR_RESP:   state_d = ao_periph_pkg::BR_IDLE;
      default:                  state_d = ao_periph_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ao_periph_pkg::BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      we_q    <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      wdata_q <= obi_req_i.wdata;
    end
    if (state_q == ao_periph_pkg::BR_ACCESS) begin
      rdata_q <= we_q ? 32'h0 : reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  always_comb begin
    reg_req_o.valid = (state_q == ao_periph_pkg::BR_ACCESS);
    reg_req_o.write = we_q;
    reg_req_o.addr  = addr_q;
    reg_req_o.wdata = wdata_q;
  end

  always_comb begin
    obi_resp_o.gnt    = gnt;
    obi_resp_o.rvalid = (state_q == ao_periph_pkg::BR_RESP);
    obi_resp_o.rdata  = rdata_q;
    obi_resp_o.err    = err_q;
  end

endmodule : obi_to_reg

// File: verilog/reg_demux.sv
// Register bus address decoder and demultiplexer
// Slot 0 is the interrupt collector, slots 1 to NUM_TIMERS the timers
`timescale 1ns/1ps

module reg_demux #(
  parameter int NUM_TIMERS = 4
) (
  input  ao_periph_pkg::reg_req_t                  reg_req_i,
  output ao_periph_pkg::reg_rsp_t                  reg_rsp_o,
  output ao_periph_pkg::reg_req_t [NUM_TIMERS:0]   slot_req_o,
  input  ao_periph_pkg::reg_rsp_t [NUM_TIMERS:0]   slot_rsp_i
);

  localparam int SEL_W = ao_periph_pkg::SLOT_BITS;
  localparam int SEL_LSB = ao_periph_pkg::SLOT_LSB;
  localparam int TOP = ao_periph_pkg::MAP_TOP;

  localparam logic [SEL_W-1:0] LAST_SLOT = SEL_W'(NUM_TIMERS);

  logic [SEL_W-1:0] slot_sel;
  logic             high_bits_set;
  logic             slot_hit;

  assign slot_sel      = reg_req_i.addr[SEL_LSB +: SEL_W];
  assign high_bits_set = |reg_req_i.addr[31:TOP];

  // Decode error when no slot owns the address
  assign slot_hit = !high_bits_set && (slot_sel <= LAST_SLOT);

  always_comb begin
    for (int i = 0; i <= NUM_TIMERS; i++) begin
      slot_req_o[i]       = reg_req_i;
      slot_req_o[i].valid = reg_req_i.valid && slot_hit && (slot_sel == SEL_W'(i));
    end
  end

  always_comb begin
    reg_rsp_o.rdata = 32'h0;
    reg_rsp_o.error = 1'b1;
    for (int i = 0; i <= NUM_TIMERS; i++) begin
      if (slot_hit && (slot_sel == SEL_W'(i))) begin
        reg_rsp_o = slot_rsp_i[i];
      end
    end
  end

endmodule : reg_demux

// File: verilog/ao_timer.sv
// Compare timer
// Counts up while enabled, wraps on reaching compare and pulses expired_o
`timescale 1ns/1ps

module ao_timer (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    expired_o
);

  localparam int SEL_LSB = ao_periph_pkg::SLOT_LSB;

  ao_periph_pkg::timer_reg_e offset;

  logic        enable_q;
  logic [31:0] cmp_q;
  logic [31:0] count_q;
  logic        expired_q;

  logic        wr_ctrl;
  logic        wr_cmp;
  logic        wr_count;
  logic        match;

  assign offset = ao_periph_pkg::timer_reg_e'(reg_req_i.addr[SEL_LSB-1:2]);

  // Write strobes per register
  always_comb begin
    wr_ctrl  = 1'b0;
    wr_cmp   = 1'b0;
    wr_count = 1'b0;
    if (reg_req_i.valid && reg_req_i.write) begin
      case (offset)
        ao_periph_pkg::TIMER_CTRL:  wr_ctrl  = 1'b1;
        ao_periph_pkg::TIMER_CMP:   wr_cmp   = 1'b1;
        ao_periph_pkg::TIMER_COUNT: wr_count = 1'b1;
        default: ;
      endcase
    end
  end

  assign match = enable_q && (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= 1'b0;
      cmp_q    <= 32'h0;
    end else begin
      if (wr_ctrl) begin
        enable_q <= reg_req_i.wdata[0];
      end
      if (wr_cmp) begin
        cmp_q <= reg_req_i.wdata;
      end
    end
  end

  // Software write to COUNT takes priority over counting
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= 32'h0;
    end else if (wr_count) begin
      count_q <= reg_req_i.wdata;
    end else if (match) begin
      count_q <= 32'h0;
    end else if (enable_q) begin
      count_q <= count_q + 32'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      expired_q <= 1'b0;
    end else begin
      expired_q <= match;
    end
  end

  assign expired_o = expired_q;

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      ao_periph_pkg::TIMER_CTRL:  reg_rsp_o.rdata = {31'h0, enable_q};
      ao_periph_pkg::TIMER_CMP:   reg_rsp_o.rdata = cmp_q;
      ao_periph_pkg::TIMER_COUNT: reg_rsp_o.rdata = count_q;
      default:                    reg_rsp_o.rdata = 32'h0;
    endcase
  end

endmodule : ao_timer

// File: verilog/intr_collect.sv
// Interrupt collector for the timer expiry pulses
// Pending bits with write-one-to-clear, a mask, and one combined interrupt
`timescale 1ns/1ps

module intr_collect #(
  parameter int NUM_TIMERS = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NUM_TIMERS-1:0]   expired_i,
  output logic                    intr_o
);

  localparam int SEL_LSB = ao_periph_pkg::SLOT_LSB;

  ao_periph_pkg::intr_reg_e offset;

  logic [NUM_TIMERS-1:0] pending_q;
  logic [NUM_TIMERS-1:0] mask_q;
  logic [NUM_TIMERS-1:0] clear;
  logic                  wr_pending;
  logic                  wr_mask;

  assign offset = ao_periph_pkg::intr_reg_e'(reg_req_i.addr[SEL_LSB-1:2]);

  always_comb begin
    wr_pending = 1'b0;
    wr_mask    = 1'b0;
    if (reg_req_i.valid && reg_req_i.write) begin
      case (offset)
        ao_periph_pkg::INTR_PENDING: wr_pending = 1'b1;
        ao_periph_pkg::INTR_MASK:    wr_mask    = 1'b1;
        default: ;
      endcase
    end
  end

  assign clear = wr_pending ? reg_req_i.wdata[NUM_TIMERS-1:0] : '0;

  // A new pulse beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear) | expired_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
    end else if (wr_mask) begin
      mask_q <= reg_req_i.wdata[NUM_TIMERS-1:0];
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      ao_periph_pkg::INTR_PENDING: reg_rsp_o.rdata = 32'(pending_q);
      ao_periph_pkg::INTR_MASK:    reg_rsp_o.rdata = 32'(mask_q);
      default:                     reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign intr_o = |(pending_q & mask_q);

endmodule : intr_collect

// File: verilog/ao_periph.sv
// Always-on peripheral block top level
// OBI bridge, slot demux, interrupt collector and NUM_TIMERS compare timers
`timescale 1ns/1ps

module ao_periph #(
  parameter int NUM_TIMERS = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  output logic                     intr_o
);

  ao_periph_pkg::reg_req_t reg_req;
  ao_periph_pkg::reg_rsp_t reg_rsp;

  ao_periph_pkg::reg_req_t [NUM_TIMERS:0] slot_req;
  ao_periph_pkg::reg_rsp_t [NUM_TIMERS:0] slot_rsp;

  logic [NUM_TIMERS-1:0] timer_expired;

  obi_to_reg u_obi_to_reg (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .obi_req_i  (obi_req_i),
    .obi_resp_o (obi_resp_o),
    .reg_req_o  (reg_req),
    .reg_rsp_i  (reg_rsp)
  );

  reg_demux #(
    .NUM_TIMERS (NUM_TIMERS)
  ) u_reg_demux (
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .slot_req_o (slot_req),
    .slot_rsp_i (slot_rsp)
  );

  intr_collect #(
    .NUM_TIMERS (NUM_TIMERS)
  ) u_intr_collect (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .reg_req_i (slot_req[0]),
    .reg_rsp_o (slot_rsp[0]),
    .expired_i (timer_expired),
    .intr_o    (intr_o)
  );

  // Timer n sits in slot n, its expiry on bit n-1
  for (genvar g = 1; g <= NUM_TIMERS; g++) begin : gen_timer
    ao_timer u_ao_timer (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .reg_req_i (slot_req[g]),
      .reg_rsp_o (slot_rsp[g]),
      .expired_o (timer_expired[g-1])
    );
  end

endmodule : ao_periph

// File: verif/tb_ao_periph.sv
// Testbench for the always-on peripheral block
// Drives the OBI port, checks replies against a register shadow model
`timescale 1ns/1ps

module tb_ao_periph;

  localparam int NUM_TIMERS = 4;
  localparam int CLK_PERIOD = 40;
  // Upper bound on the transactions issued
  localparam int NUM_TRANS = 120;
  localparam int WAIT_CYCLES = 16;
  localparam int RESET_CYCLES = 2;
  localparam int MARGIN_CYCLES = 40;
  localparam int TIMEOUT_NS =
    (NUM_TRANS * 3 + WAIT_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic                     clk_i;
  logic                     rst_i;
  ao_periph_pkg::obi_req_t  obi_req;
  ao_periph_pkg::obi_resp_t obi_resp;
  logic                     intr;

  integer seed;

  // Shadow copy of every register
  logic                  sh_en [1:NUM_TIMERS];
  logic [31:0]           sh_cmp [1:NUM_TIMERS];
  logic [31:0]           sh_count [1:NUM_TIMERS];
  logic [NUM_TIMERS-1:0] sh_pending;
  logic [NUM_TIMERS-1:0] sh_mask;

  ao_periph #(
    .NUM_TIMERS (NUM_TIMERS)
  ) u_ao_periph (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .obi_req_i  (obi_req),
    .obi_resp_o (obi_resp),
    .intr_o     (intr)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_intr(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch intr_o: got 0x%0h expected 0x%0h", got, exp));
    end
  endtask

  function automatic logic [31:0] reg_addr(input int slot, input int off);
    return 32'(slot * 16 + off * 4);
  endfunction

  // Bits 31..12 clear and the slot owned by the collector or a timer
  function automatic logic in_map(input logic [31:0] addr);
    return (addr[31:12] == '0) && (32'(addr[11:4]) <= NUM_TIMERS);
  endfunction

  // Slot in bits 11..4, word offset in bits 3..2
  function automatic void ref_read(input logic [31:0] addr, output logic [31:0] rdata,
                                   output logic err);
    int slot;
    int off;
    slot  = 32'(addr[11:4]);
    off   = 32'(addr[3:2]);
    rdata = 32'h0;
    err   = 1'b0;
    if (!in_map(addr)) begin
      err = 1'b1;
    end else if (slot == 0) begin
      case (off)
        0: rdata = 32'(sh_pending);
        1: rdata = 32'(sh_mask);
        default: rdata = 32'h0;
      endcase
    end else begin
      case (off)
        0: rdata = {31'h0, sh_en[slot]};
        1: rdata = sh_cmp[slot];
        2: rdata = sh_count[slot];
        default: rdata = 32'h0;
      endcase
    end
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata);
    int slot;
    int off;
    slot = 32'(addr[11:4]);
    off  = 32'(addr[3:2]);
    if (in_map(addr)) begin
      if (slot == 0) begin
        // PENDING is write-one-to-clear
        if (off == 0) sh_pending = sh_pending & ~wdata[NUM_TIMERS-1:0];
        if (off == 1) sh_mask = wdata[NUM_TIMERS-1:0];
      end else begin
        if (off == 0) sh_en[slot] = wdata[0];
        if (off == 1) sh_cmp[slot] = wdata;
        if (off == 2) sh_count[slot] = wdata;
      end
    end
  endtask

  // Hold the request until granted, then wait for rvalid
  task automatic obi_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk_i);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    #(CLK_PERIOD / 4);
    while (!obi_resp.gnt) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
    @(negedge clk_i);
    obi_req = '0;
    #(CLK_PERIOD / 4);
    while (!obi_resp.rvalid) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
    rdata = obi_resp.rdata;
    err   = obi_resp.err;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    logic        exp_err;
    exp_err = !in_map(addr);
    obi_access(1'b1, addr, wdata, rdata, err);
    model_write(addr, wdata);
    check_rdata($sformatf("obi_resp_o.rdata write @0x%08h", addr), rdata, 32'h0);
    check_err($sformatf("obi_resp_o.err write @0x%08h", addr), err, exp_err);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    obi_access(1'b0, addr, 32'h0, rdata, err);
  endtask

  task automatic read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    logic [31:0] exp_rdata;
    logic        exp_err;
    obi_read(addr, rdata, err);
    ref_read(addr, exp_rdata, exp_err);
    check_rdata($sformatf("obi_resp_o.rdata @0x%08h", addr), rdata, exp_rdata);
    check_err($sformatf("obi_resp_o.err @0x%08h", addr), err, exp_err);
  endtask

  // Every offset of every slot including the unused ones
  task automatic check_all();
    for (int s = 0; s <= NUM_TIMERS; s++) begin
      for (int o = 0; o < 4; o++) begin
        read_check(reg_addr(s, o));
      end
    end
    check_intr(intr, |(sh_pending & sh_mask));
  endtask

  initial begin
    #(TIMEOUT_NS);
    report_failure("watchdog expired: the run hung waiting for the DUT");
  end

  initial begin
    logic [31:0] value;
    logic [31:0] rdata;
    logic        err;
    logic [31:0] bit_t;
    int          t;
    int          c;
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    obi_req = '0;
    seed    = 32'h348a;
    sh_pending = '0;
    sh_mask    = '0;
    for (int i = 1; i <= NUM_TIMERS; i++) begin
      sh_en[i]    = 1'b0;
      sh_cmp[i]   = 32'h0;
      sh_count[i] = 32'h0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Reset values
    check_intr(intr, 1'b0);
    check_all();

    // CMP and MASK read back
    for (int i = 1; i <= NUM_TIMERS; i++) begin
      value = $random(seed);
      obi_write(reg_addr(i, 1), value);
    end
    value = $random(seed);
    obi_write(reg_addr(0, 1), value);
    for (int i = 1; i <= NUM_TIMERS; i++) begin
      read_check(reg_addr(i, 1));
    end
    read_check(reg_addr(0, 1));

    // Slots past the last timer and set high address bits
    read_check(reg_addr(NUM_TIMERS + 1, 0));
    read_check(32'h0000_0ff0);
    read_check(32'h0000_1010);
    read_check(32'h8000_0014);
    obi_write(reg_addr(NUM_TIMERS + 1, 0), 32'hffff_ffff);
    obi_write(32'h0000_0ff0, 32'hffff_ffff);
    obi_write(32'h0000_1010, 32'hffff_ffff);
    obi_write(32'h8000_0014, 32'hffff_ffff);
    check_all();

    // Run one timer to expiry
    t = 1 + ($unsigned($random(seed)) % NUM_TIMERS);
    c = 2 + ($unsigned($random(seed)) % 8);
    bit_t = 32'(1) << (t - 1);
    obi_write(reg_addr(t, 1), 32'(c));
    obi_write(reg_addr(t, 0), 32'h1);
    repeat (c + 6) @(negedge clk_i);
    sh_pending[t-1] = 1'b1;
    read_check(reg_addr(0, 0));
    obi_read(reg_addr(t, 2), rdata, err);
    check_err("obi_resp_o.err COUNT", err, 1'b0);
    if (rdata > 32'(c)) begin
      report_failure($sformatf("mismatch obi_resp_o.rdata: COUNT 0x%08h above compare 0x%08h",
                               rdata, 32'(c)));
    end

    // Mask in, mask out, then disable and clear
    obi_write(reg_addr(0, 1), bit_t);
    check_intr(intr, 1'b1);
    obi_write(reg_addr(0, 1), ~bit_t);
    check_intr(intr, 1'b0);
    obi_write(reg_addr(0, 1), bit_t);
    check_intr(intr, 1'b1);
    obi_write(reg_addr(t, 0), 32'h0);
    obi_write(reg_addr(0, 0), bit_t);
    read_check(reg_addr(0, 0));
    check_intr(intr, 1'b0);

    // COUNT is writable on a stopped timer
    value = $random(seed);
    obi_write(reg_addr(t, 2), value);
    read_check(reg_addr(t, 2));
    value = $random(seed);
    obi_write(reg_addr((t % NUM_TIMERS) + 1, 2), value);
    read_check(reg_addr((t % NUM_TIMERS) + 1, 2));
    check_all();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_ao_periph

// File: ao_periph.f
verilog/ao_periph_pkg.sv
verilog/obi_to_reg.sv
verilog/reg_demux.sv
verilog/ao_timer.sv
verilog/intr_collect.sv
verilog/ao_periph.sv
verif/tb_ao_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build the always-on peripheral testbench with Verilator and run it.
# The exit status is the simulator's own, nonzero on a failed check.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=build/obj_dir

verilator --binary --timing \
  -f ao_periph.f \
  --top-module tb_ao_periph \
  -Mdir "$OBJ_DIR" \
  -o sim_tb_ao_periph
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$OBJ_DIR/sim_tb_ao_periph"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished with status 0"
exit 0
